/* core_pkg.sv */
package core_pkg;

	parameter int WORD_W   = 16; // Data path width
	parameter int ADDR_W   = 16; // Word address width
	parameter int NUM_REGS = 8;
	parameter int REG_W    = 3;  // Register index width

	typedef struct packed {
		logic s; // Sign
		logic z; // Zero
		logic c; // Carry or borrow
		logic v; // Signed overflow
	} flags_t;

	// Operation class resolved in decode. Nine classes need a 4-bit encoding
	typedef enum logic [3:0] {
		CLS_ALU,
		CLS_MOV,
		CLS_CMP,
		CLS_LI,
		CLS_LD,
		CLS_ST,
		CLS_BR,
		CLS_HLT,
		CLS_NOP
	} op_class_t;

endpackage

/* isa_pkg.sv */
package isa_pkg;

	// Major opcode in bits 15:14
	parameter logic [1:0] OP_LD  = 2'b00;
	parameter logic [1:0] OP_ST  = 2'b01;
	parameter logic [1:0] OP_IMM = 2'b10;
	parameter logic [1:0] OP_ALU = 2'b11;

	// op3 codes under OP_ALU
	parameter logic [3:0] F3_ADD = 4'b0000;
	parameter logic [3:0] F3_SUB = 4'b0001;
	parameter logic [3:0] F3_AND = 4'b0010;
	parameter logic [3:0] F3_OR  = 4'b0011;
	parameter logic [3:0] F3_XOR = 4'b0100;
	parameter logic [3:0] F3_CMP = 4'b0101;
	parameter logic [3:0] F3_MOV = 4'b0110;
	parameter logic [3:0] F3_HLT = 4'b1111;

	// ra field under OP_IMM
	parameter logic [2:0] GRP_LI  = 3'b000;
	parameter logic [2:0] GRP_B   = 3'b100;
	parameter logic [2:0] GRP_BCC = 3'b111;

	// rb field under GRP_BCC
	parameter logic [2:0] CC_BE  = 3'b000;
	parameter logic [2:0] CC_BLT = 3'b001;
	parameter logic [2:0] CC_BLE = 3'b010;
	parameter logic [2:0] CC_BNE = 3'b011;

	typedef struct packed {
		logic [1:0] op;
		logic [2:0] ra;
		logic [2:0] rb;
		logic [3:0] op3;
		logic [3:0] unused;
	} alu_fmt_t;

	typedef struct packed {
		logic [1:0] op;
		logic [2:0] ra;
		logic [2:0] rb;
		logic [7:0] d; // Signed displacement or immediate
	} imm_fmt_t;

	// One instruction word, read as register form or immediate form
	typedef union packed {
		alu_fmt_t alu_fmt;
		imm_fmt_t imm_fmt;
	} insn_t;

endpackage

/* stage_if.sv */
`timescale 1ns/100ps

interface stage_if import core_pkg::*, isa_pkg::*; ();

	logic                valid;
	logic                ready;
	logic [ADDR_W-1:0]   pc;
	insn_t               insn;
	op_class_t           cls;
	logic [WORD_W-1:0]   opa;     // r[ra]
	logic [WORD_W-1:0]   opb;     // r[rb]
	logic [WORD_W-1:0]   result;  // Immediate, address or data
	logic [ADDR_W-1:0]   next_pc;

	modport source (output valid, pc, insn, cls, opa, opb, result, next_pc, input ready);
	modport sink (input valid, pc, insn, cls, opa, opb, result, next_pc, output ready);

endinterface

/* fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage import core_pkg::*; #(
	parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic              retire,
	input  logic [ADDR_W-1:0] retire_pc,
	input  logic              retire_halt,
	output logic              imem_valid,
	output logic [ADDR_W-1:0] imem_addr,
	input  logic              imem_ready,
	input  logic [WORD_W-1:0] imem_rdata,
	output logic              halted,
	stage_if.source           out
);

	typedef enum logic [2:0] {F_IDLE, F_FETCH, F_SEND, F_WAIT, F_HALT} fstate_t;

	fstate_t           state;
	logic [ADDR_W-1:0] pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= F_IDLE;
			pc    <= RESET_PC;
		end else begin
			case (state)
				F_IDLE:  if (start) state <= F_FETCH;
				F_FETCH: if (imem_ready) state <= F_SEND;
				F_SEND:  if (out.ready) state <= F_WAIT;
				F_WAIT: begin
					if (retire) begin // Previous instruction done
						pc    <= retire_pc;
						state <= retire_halt ? F_HALT : F_FETCH;
					end
				end
				default: state <= F_HALT; // Stays until rst
			endcase
		end
	end

	// Instruction word captured at the fetch handshake
	always_ff @(posedge clk) begin
		if (state == F_FETCH && imem_ready)
			out.insn <= imem_rdata;
	end

	assign imem_valid  = (state == F_FETCH);
	assign imem_addr   = pc;
	assign halted      = (state == F_HALT);

	assign out.valid   = (state == F_SEND);
	assign out.pc      = pc;
	assign out.cls     = CLS_NOP; // Classified in decode
	assign out.opa     = '0;
	assign out.opb     = '0;
	assign out.result  = '0;
	assign out.next_pc = pc + ADDR_W'(1);

endmodule

/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import core_pkg::*, isa_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	stage_if.sink             in,
	stage_if.source           out,
	input  logic              rf_we,
	input  logic [REG_W-1:0]  rf_waddr,
	input  logic [WORD_W-1:0] rf_wdata
);

	logic [WORD_W-1:0] regs [NUM_REGS];
	op_class_t         cls;
	logic [WORD_W-1:0] imm;
	logic              take;

	assign take     = in.valid && in.ready;
	assign in.ready = !out.valid || out.ready;
	assign imm      = {{(WORD_W-8){in.insn.imm_fmt.d[7]}}, in.insn.imm_fmt.d};

	always_ff @(posedge clk) begin
		if (rf_we)
			regs[rf_waddr] <= rf_wdata;
	end

	// Pick the format by major opcode, then classify
	always_comb begin
		cls = CLS_NOP;
		case (in.insn.imm_fmt.op)
			OP_LD: cls = CLS_LD;
			OP_ST: cls = CLS_ST;
			OP_IMM: begin
				case (in.insn.imm_fmt.ra)
					GRP_LI: cls = CLS_LI;
					GRP_B:  cls = CLS_BR;
					GRP_BCC: begin
						if (in.insn.imm_fmt.rb inside {CC_BE, CC_BLT, CC_BLE, CC_BNE})
							cls = CLS_BR;
					end
					default: cls = CLS_NOP;
				endcase
			end
			default: begin // OP_ALU
				case (in.insn.alu_fmt.op3)
					F3_ADD, F3_SUB, F3_AND, F3_OR, F3_XOR: cls = CLS_ALU;
					F3_CMP:  cls = CLS_CMP;
					F3_MOV:  cls = CLS_MOV;
					F3_HLT:  cls = CLS_HLT;
					default: cls = CLS_NOP;
				endcase
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			out.valid <= 1'b0;
		else if (take)
			out.valid <= 1'b1;
		else if (out.ready)
			out.valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out.pc      <= in.pc;
			out.insn    <= in.insn;
			out.cls     <= cls;
			out.opa     <= regs[in.insn.imm_fmt.ra];
			out.opb     <= regs[in.insn.imm_fmt.rb];
			out.result  <= imm; // LI value or LD/ST/branch offset
			out.next_pc <= in.next_pc;
		end
	end

endmodule

/* execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import core_pkg::*, isa_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	stage_if.sink   in,
	stage_if.source out
);

	flags_t            flags;
	flags_t            alu_flags;
	logic [WORD_W-1:0] alu_res;
	logic [WORD_W:0]   add_res;
	logic [WORD_W:0]   sub_res;
	logic [WORD_W-1:0] result;
	logic              taken;
	logic              take;

	assign take     = in.valid && in.ready;
	assign in.ready = !out.valid || out.ready;

	assign add_res = {1'b0, in.opb} + {1'b0, in.opa}; // r[rb] + r[ra]
	assign sub_res = {1'b0, in.opb} - {1'b0, in.opa}; // r[rb] - r[ra]

	always_comb begin
		alu_res     = '0;
		alu_flags.c = flags.c;
		alu_flags.v = flags.v;
		case (in.insn.alu_fmt.op3)
			F3_ADD: begin
				alu_res     = add_res[WORD_W-1:0];
				alu_flags.c = add_res[WORD_W];
				alu_flags.v = (in.opb[WORD_W-1] == in.opa[WORD_W-1])
					&& (alu_res[WORD_W-1] != in.opb[WORD_W-1]);
			end
			F3_SUB, F3_CMP: begin
				alu_res     = sub_res[WORD_W-1:0];
				alu_flags.c = sub_res[WORD_W]; // Borrow
				alu_flags.v = (in.opb[WORD_W-1] != in.opa[WORD_W-1])
					&& (alu_res[WORD_W-1] != in.opb[WORD_W-1]);
			end
			F3_AND, F3_OR, F3_XOR: begin
				if (in.insn.alu_fmt.op3 == F3_AND)
					alu_res = in.opb & in.opa;
				else if (in.insn.alu_fmt.op3 == F3_OR)
					alu_res = in.opb | in.opa;
				else
					alu_res = in.opb ^ in.opa;
				alu_flags.c = 1'b0;
				alu_flags.v = 1'b0;
			end
			default: alu_res = '0;
		endcase
		alu_flags.s = alu_res[WORD_W-1];
		alu_flags.z = (alu_res == '0);
	end

	always_comb begin
		case (in.cls)
			CLS_ALU:        result = alu_res;
			CLS_MOV:        result = in.opa;
			CLS_LD, CLS_ST: result = in.opb + in.result; // Base plus offset
			default:        result = in.result;
		endcase
	end

	// Branch condition from the flags left by earlier instructions
	always_comb begin
		taken = 1'b0;
		if (in.cls == CLS_BR) begin
			if (in.insn.imm_fmt.ra == GRP_B)
				taken = 1'b1;
			else begin
				case (in.insn.imm_fmt.rb)
					CC_BE:   taken = flags.z;
					CC_BLT:  taken = flags.s ^ flags.v;
					CC_BLE:  taken = flags.z || (flags.s ^ flags.v);
					CC_BNE:  taken = !flags.z;
					default: taken = 1'b0;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out.valid <= 1'b0;
			flags     <= '0;
		end else begin
			if (take && (in.cls == CLS_ALU || in.cls == CLS_CMP))
				flags <= alu_flags;
			if (take)
				out.valid <= 1'b1;
			else if (out.ready)
				out.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out.pc      <= in.pc;
			out.insn    <= in.insn;
			out.cls     <= in.cls;
			out.opa     <= in.opa; // Store data rides along
			out.opb     <= in.opb;
			out.result  <= result;
			out.next_pc <= taken ? in.next_pc + ADDR_W'(in.result) : in.next_pc;
		end
	end

endmodule

/* memory_stage.sv */
`timescale 1ns/100ps

module memory_stage import core_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	stage_if.sink             in,
	stage_if.source           out,
	output logic              dmem_valid,
	output logic              dmem_write,
	output logic [ADDR_W-1:0] dmem_addr,
	output logic [WORD_W-1:0] dmem_wdata,
	input  logic              dmem_ready,
	input  logic [WORD_W-1:0] dmem_rdata
);

	logic take;
	logic is_mem;
	logic dmem_done;

	assign is_mem    = (in.cls == CLS_LD) || (in.cls == CLS_ST);
	assign dmem_done = dmem_valid && dmem_ready;
	assign take      = in.valid && in.ready;
	assign in.ready  = !dmem_valid && (!out.valid || out.ready);

	// Request fields come from the held record, so they stay put during a stall
	assign dmem_addr  = ADDR_W'(out.result);
	assign dmem_wdata = out.opa;
	assign dmem_write = (out.cls == CLS_ST);

	always_ff @(posedge clk) begin
		if (rst) begin
			out.valid  <= 1'b0;
			dmem_valid <= 1'b0;
		end else if (dmem_valid) begin
			if (dmem_ready) begin
				dmem_valid <= 1'b0;
				out.valid  <= 1'b1;
			end
		end else if (take) begin
			dmem_valid <= is_mem;
			out.valid  <= !is_mem; // Others pass in one cycle
		end else if (out.ready) begin
			out.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out.pc      <= in.pc;
			out.insn    <= in.insn;
			out.cls     <= in.cls;
			out.opa     <= in.opa;
			out.opb     <= in.opb;
			out.result  <= in.result;
			out.next_pc <= in.next_pc;
		end else if (dmem_done && out.cls == CLS_LD) begin
			out.result <= dmem_rdata; // Loaded word replaces the address
		end
	end

endmodule

/* writeback_stage.sv */
`timescale 1ns/100ps

module writeback_stage import core_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	stage_if.sink             in,
	output logic              rf_we,
	output logic [REG_W-1:0]  rf_waddr,
	output logic [WORD_W-1:0] rf_wdata,
	output logic              retire,
	output logic [ADDR_W-1:0] retire_pc,
	output logic              retire_halt
);

	logic             wr_en;
	logic [REG_W-1:0] wr_reg;

	assign in.ready = 1'b1;

	always_comb begin
		wr_en  = 1'b0;
		wr_reg = in.insn.imm_fmt.rb;
		case (in.cls)
			CLS_ALU, CLS_MOV, CLS_LI: wr_en = 1'b1;
			CLS_LD: begin
				wr_en  = 1'b1;
				wr_reg = in.insn.imm_fmt.ra; // LD targets ra
			end
			default: wr_en = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rf_we  <= 1'b0;
			retire <= 1'b0;
		end else begin
			rf_we  <= in.valid && wr_en;
			retire <= in.valid; // One pulse per record
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid) begin
			rf_waddr    <= wr_reg;
			rf_wdata    <= in.result;
			retire_pc   <= in.next_pc;
			retire_halt <= (in.cls == CLS_HLT);
		end
	end

endmodule

/* cpu_top.sv */
`timescale 1ns/100ps

module cpu_top import core_pkg::*; #(
	parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	output logic              halted,
	output logic              imem_valid,
	output logic [ADDR_W-1:0] imem_addr,
	input  logic              imem_ready,
	input  logic [WORD_W-1:0] imem_rdata,
	output logic              dmem_valid,
	output logic              dmem_write,
	output logic [ADDR_W-1:0] dmem_addr,
	output logic [WORD_W-1:0] dmem_wdata,
	input  logic              dmem_ready,
	input  logic [WORD_W-1:0] dmem_rdata
);

	logic              rf_we;
	logic [REG_W-1:0]  rf_waddr;
	logic [WORD_W-1:0] rf_wdata;
	logic              retire;
	logic [ADDR_W-1:0] retire_pc;
	logic              retire_halt;

	stage_if f2d ();
	stage_if d2e ();
	stage_if e2m ();
	stage_if m2w ();

	fetch_stage #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.retire      (retire),
		.retire_pc   (retire_pc),
		.retire_halt (retire_halt),
		.imem_valid  (imem_valid),
		.imem_addr   (imem_addr),
		.imem_ready  (imem_ready),
		.imem_rdata  (imem_rdata),
		.halted      (halted),
		.out         (f2d.source)
	);

	decode_stage u_decode (
		.clk      (clk),
		.rst      (rst),
		.in       (f2d.sink),
		.out      (d2e.source),
		.rf_we    (rf_we),
		.rf_waddr (rf_waddr),
		.rf_wdata (rf_wdata)
	);

	execute_stage u_execute (
		.clk (clk),
		.rst (rst),
		.in  (d2e.sink),
		.out (e2m.source)
	);

	memory_stage u_memory (
		.clk        (clk),
		.rst        (rst),
		.in         (e2m.sink),
		.out        (m2w.source),
		.dmem_valid (dmem_valid),
		.dmem_write (dmem_write),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_ready (dmem_ready),
		.dmem_rdata (dmem_rdata)
	);

	writeback_stage u_writeback (
		.clk         (clk),
		.rst         (rst),
		.in          (m2w.sink),
		.rf_we       (rf_we),
		.rf_waddr    (rf_waddr),
		.rf_wdata    (rf_wdata),
		.retire      (retire),
		.retire_pc   (retire_pc),
		.retire_halt (retire_halt)
	);

endmodule

/* tb_checker.sv */
`timescale 1ns/100ps

module tb_checker #(
	parameter int COUNT_BASE = 'h60,
	parameter int FETCH_BASE = 'h80,
	parameter int STORE_BASE = 'hC0,
	parameter int MIN_GAP    = 5 // Idle cycles from fetch to retire
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        imem_valid,
	input  logic        imem_ready,
	input  logic [15:0] imem_addr,
	input  logic        dmem_valid,
	input  logic        dmem_ready,
	input  logic        dmem_write,
	input  logic [15:0] dmem_addr,
	input  logic [15:0] dmem_wdata,
	input  logic        halted,
	input  logic [15:0] trace [256],
	output int          errors,
	output int          fetch_seen,
	output int          store_seen
);

	int          reset_edges;
	int          gap;
	logic        gap_armed;
	logic        was_halted;
	logic        i_hold;
	logic        d_hold;
	logic [15:0] i_addr_q;
	logic [15:0] d_addr_q;
	logic [15:0] d_wdata_q;
	logic        d_write_q;

	task automatic report_mismatch(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
		errors++;
	endtask

	task automatic note_failure(input string what);
		$display("Failure at %0t: %s", $time, what);
		errors++;
	endtask

	initial begin
		errors      = 0;
		fetch_seen  = 0;
		store_seen  = 0;
		reset_edges = 0;
		gap         = 0;
		gap_armed   = 1'b0;
		was_halted  = 1'b0;
		i_hold      = 1'b0;
		d_hold      = 1'b0;
		forever begin
			@(posedge clk);
			if (rst) begin
				reset_edges++;
				if (reset_edges > 1 && (imem_valid || dmem_valid || halted))
					note_failure("memory valid or halted high during reset");
				i_hold     = 1'b0;
				d_hold     = 1'b0;
				gap_armed  = 1'b0;
				was_halted = 1'b0;
			end else begin
				// Request fields must hold while stalled
				if (i_hold) begin
					if (!imem_valid)
						note_failure("imem_valid dropped before its transfer");
					else if (imem_addr != i_addr_q)
						report_mismatch("imem_addr", i_addr_q, imem_addr);
				end
				if (d_hold) begin
					if (!dmem_valid)
						note_failure("dmem_valid dropped before its transfer");
					else begin
						if (dmem_addr != d_addr_q)
							report_mismatch("dmem_addr", d_addr_q, dmem_addr);
						if (dmem_write != d_write_q)
							report_mismatch("dmem_write", 16'(d_write_q), 16'(dmem_write));
						if (dmem_wdata != d_wdata_q)
							report_mismatch("dmem_wdata", d_wdata_q, dmem_wdata);
					end
				end

				if (imem_valid && gap_armed) begin
					if (gap < MIN_GAP)
						note_failure("fetch issued while an instruction was in flight");
					gap_armed = 1'b0;
				end else if (gap_armed) begin
					gap++;
				end

				if (imem_valid && imem_ready) begin
					if (fetch_seen >= int'(trace[8'(COUNT_BASE)]))
						note_failure("more fetches than the trace lists");
					else if (imem_addr != trace[8'(FETCH_BASE + fetch_seen)])
						report_mismatch("imem_addr", trace[8'(FETCH_BASE + fetch_seen)],
							imem_addr);
					fetch_seen++;
					gap_armed = 1'b1;
					gap       = 0;
				end

				if (dmem_valid && dmem_ready && dmem_write) begin
					if (store_seen >= int'(trace[8'(COUNT_BASE + 1)])) begin
						note_failure("more stores than the trace lists");
					end else begin
						if (dmem_addr != trace[8'(STORE_BASE + 2 * store_seen)])
							report_mismatch("dmem_addr",
								trace[8'(STORE_BASE + 2 * store_seen)], dmem_addr);
						if (dmem_wdata != trace[8'(STORE_BASE + 2 * store_seen + 1)])
							report_mismatch("dmem_wdata",
								trace[8'(STORE_BASE + 2 * store_seen + 1)], dmem_wdata);
					end
					store_seen++;
				end

				if (was_halted && !halted)
					note_failure("halted dropped without a reset");
				if (halted && imem_valid)
					note_failure("instruction fetch after halt");
				was_halted = halted;

				i_hold    = imem_valid && !imem_ready;
				i_addr_q  = imem_addr;
				d_hold    = dmem_valid && !dmem_ready;
				d_addr_q  = dmem_addr;
				d_write_q = dmem_write;
				d_wdata_q = dmem_wdata;
			end
		end
	end

endmodule

/* tb_cpu_top.sv */
`timescale 1ns/100ps

module tb_cpu_top;

	localparam int DATA_BASE       = 'h40; // Trace offsets
	localparam int COUNT_BASE      = 'h60;
	localparam int FETCH_BASE      = 'h80;
	localparam int STORE_BASE      = 'hC0;
	localparam int DATA_WORDS      = 8;
	localparam int DATA_ADDR       = 'h10;
	localparam int CYCLES_PER_INSN = 40; // Pipeline depth plus stall slack

	logic        clk;
	logic        rst;
	logic        start;
	logic        halted;
	logic        imem_valid;
	logic [15:0] imem_addr;
	logic        imem_ready;
	logic [15:0] imem_rdata;
	logic        dmem_valid;
	logic        dmem_write;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_wdata;
	logic        dmem_ready;
	logic [15:0] dmem_rdata;

	logic [15:0] trace [256];
	logic [15:0] dmem [256];
	logic [31:0] lfsr;
	int          cycles;
	int          limit;
	int          n_fetch;
	int          n_store;
	int          run_errors;
	int          check_errors;
	int          fetch_seen;
	int          store_seen;

	cpu_top #(
		.RESET_PC (16'h0000)
	) DUT (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.halted     (halted),
		.imem_valid (imem_valid),
		.imem_addr  (imem_addr),
		.imem_ready (imem_ready),
		.imem_rdata (imem_rdata),
		.dmem_valid (dmem_valid),
		.dmem_write (dmem_write),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_ready (dmem_ready),
		.dmem_rdata (dmem_rdata)
	);

	tb_checker #(
		.COUNT_BASE (COUNT_BASE),
		.FETCH_BASE (FETCH_BASE),
		.STORE_BASE (STORE_BASE)
	) u_checker (
		.clk        (clk),
		.rst        (rst),
		.imem_valid (imem_valid),
		.imem_ready (imem_ready),
		.imem_addr  (imem_addr),
		.dmem_valid (dmem_valid),
		.dmem_ready (dmem_ready),
		.dmem_write (dmem_write),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.halted     (halted),
		.trace      (trace),
		.errors     (check_errors),
		.fetch_seen (fetch_seen),
		.store_seen (store_seen)
	);

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic random_bit(output logic b);
		lfsr = lfsr_step(lfsr);
		b    = lfsr[0];
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Memory models, ready about three cycles in four
	initial begin
		logic b0;
		logic b1;
		lfsr       = 32'h58c5_96f1;
		imem_ready = 1'b0;
		imem_rdata = 16'h0000;
		dmem_ready = 1'b0;
		dmem_rdata = 16'h0000;
		for (int i = 0; i < 256; i++)
			trace[8'(i)] = {8'hEE, 8'(i)};
		$readmemh("cpu_trace.txt", trace);
		for (int a = 0; a < 256; a++)
			dmem[8'(a)] = {~8'(a), 8'(a)};
		for (int i = 0; i < DATA_WORDS; i++)
			dmem[8'(DATA_ADDR + i)] = trace[8'(DATA_BASE + i)];
		forever begin
			@(posedge clk);
			if (dmem_valid && dmem_ready && dmem_write)
				dmem[dmem_addr[7:0]] = dmem_wdata;
			@(negedge clk);
			random_bit(b0);
			random_bit(b1);
			imem_ready = b0 | b1;
			random_bit(b0);
			random_bit(b1);
			dmem_ready = b0 | b1;
			imem_rdata = trace[{2'b00, imem_addr[5:0]}]; // Program lives in 0x00..0x3F
			dmem_rdata = dmem[dmem_addr[7:0]];
		end
	end

	initial begin
		cycles     = 0;
		run_errors = 0;
		rst        = 1'b1;
		start      = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;

		n_fetch = int'(trace[8'(COUNT_BASE)]);
		n_store = int'(trace[8'(COUNT_BASE + 1)]);
		limit   = (n_fetch + n_store) * CYCLES_PER_INSN;

		while (!halted && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("Timeout: core did not halt within %0d cycles", limit);
			$display("TESTS FAILED");
			$finish;
		end else begin
			// Keep watching for stray fetches until the limit
			while (cycles < limit) begin
				@(posedge clk);
				cycles++;
			end
			if (fetch_seen != n_fetch) begin
				$display("Saw %0d fetches but the trace lists %0d", fetch_seen, n_fetch);
				run_errors++;
			end
			if (store_seen != n_store) begin
				$display("Saw %0d stores but the trace lists %0d", store_seen, n_store);
				run_errors++;
			end
			$display("Errors: %0d checker, %0d end of run; fetches %0d, stores %0d",
				check_errors, run_errors, fetch_seen, store_seen);
			if (check_errors == 0 && run_errors == 0)
				$display("TESTS PASSED");
			else
				$display("TESTS FAILED");
			$finish;
		end
	end

endmodule

/* cpu_top.f */
core_pkg.sv
isa_pkg.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
writeback_stage.sv
cpu_top.sv
tb_checker.sv
tb_cpu_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the cpu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cpu_top -f cpu_top.f -o sim_cpu
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
	exit 0
else
	exit 1
fi

/* cpu_trace.txt */
// Hex words by offset: @00 program, @40 data words for dmem 0x0010..0x0017,
// @60 fetch count then store count, @80 fetch addresses, @C0 store address/data pairs
@00
8105 // LI r1, 5
82FD // LI r2, -3
8720 // LI r7, 0x20
CB60 // MOV r3, r1
D300 // ADD r3, r2
5F00 // ST r3, [r7+0]
CC60 // MOV r4, r1
D410 // SUB r4, r2
6701 // ST r4, [r7+1]
D560 // MOV r5, r2
CD20 // AND r5, r1
E530 // OR r5, r4
D540 // XOR r5, r2
6F02 // ST r5, [r7+2]
8610 // LI r6, 0x10
0E03 // LD r1, [r6+3]
4F03 // ST r1, [r7+3]
0FF1 // LD r1, [r7-15]
4E14 // ST r1, [r6+0x14]
DB50 // CMP r3, r3
BB05 // BNE +5, not taken
B801 // BE +1, taken
C0F0 // HLT, skipped
DC50 // CMP r4, r3
B901 // BLT +1, not taken
BA01 // BLE +1, not taken
E350 // CMP r3, r4
B902 // BLT +2, taken
C0F0 // HLT, skipped
C0F0 // HLT, skipped
BA01 // BLE +1, taken
C0F0 // HLT, skipped
BB01 // BNE +1, taken
C0F0 // HLT, skipped
A002 // B +2
6705 // ST r4, [r7+5]
C0F0 // HLT
A0FD // B -3
@40
1234
5678
9ABC
DEF0
0F0F
F0F0
0001
8000
@60
0021 // 33 fetches
0006 // 6 stores
@80
0000 0001 0002 0003 0004 0005 0006 0007
0008 0009 000A 000B 000C 000D 000E 000F
0010 0011 0012 0013 0014 0015 0017 0018
0019 001A 001B 001E 0020 0022 0025 0023
0024
@C0
0020 0002
0021 0008
0022 FFF0
0023 DEF0
0024 5678
0025 0008
